//--- hdl/mcu_bridge_pkg.sv
`default_nettype none

package mcu_bridge_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [7:0] reg_addr_t;     // Also the buffer address byte.
    typedef logic [15:0] word_t;
    typedef logic [8:0] buf_index_t;
    typedef logic [31:0] bus_addr_t;
    typedef logic [11:0] cfg_flags_t;

    typedef enum logic [7:0] {
        CMD_IDENTIFY,
        CMD_REG_READ,
        CMD_REG_WRITE,
        CMD_MEM_READ,
        CMD_MEM_WRITE
    } cmd_e;

    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_ADDRESS,
        PHASE_DATA,
        PHASE_NOP
    } phase_e;

    // Numbering matches the firmware register map, hence the gaps.
    typedef enum logic [7:0] {
        REG_MEM_ADDRESS = 8'd0,
        REG_MEM_SCR = 8'd1,
        REG_CFG_SCR = 8'd6,
        REG_CFG_IDENTIFIER = 8'd10
    } reg_addr_e;

    localparam byte_t FPGA_ID = 8'h64;
    localparam reg_data_t CFG_IDENTIFIER = 32'h5343_7632;
    localparam cfg_flags_t CFG_RESET = 12'h001;    // Bootloader enabled.
    localparam int BUF_WORDS = 512;

endpackage

`default_nettype wire

//--- hdl/mcu_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_bridge_top (
    input wire logic clk,
    input wire logic reset,

    input wire logic frame_start,
    input wire logic data_ready,
    input wire mcu_bridge_pkg::byte_t rx_data,
    output mcu_bridge_pkg::byte_t tx_data,

    output mcu_bridge_pkg::cfg_flags_t cfg_flags,

    output logic mem_request,
    output logic mem_write,
    output mcu_bridge_pkg::bus_addr_t mem_address,
    output mcu_bridge_pkg::word_t mem_wdata,
    input wire logic mem_ack,
    input wire mcu_bridge_pkg::word_t mem_rdata
);

    logic reg_read;
    logic reg_write;
    mcu_bridge_pkg::reg_addr_t reg_address;
    mcu_bridge_pkg::reg_data_t reg_wdata;
    mcu_bridge_pkg::reg_data_t reg_rdata;

    logic buf_read;
    logic buf_write;
    mcu_bridge_pkg::buf_index_t buf_index;
    mcu_bridge_pkg::word_t buf_wdata;
    mcu_bridge_pkg::word_t buf_rdata;

    logic dma_start;
    logic dma_stop;
    logic dma_direction;
    mcu_bridge_pkg::buf_index_t dma_length;
    mcu_bridge_pkg::bus_addr_t dma_address;
    logic dma_busy;

    mcu_frame_parser parser_inst (
        .clk(clk),
        .reset(reset),
        .frame_start(frame_start),
        .data_ready(data_ready),
        .rx_data(rx_data),
        .tx_data(tx_data),
        .reg_read(reg_read),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .buf_read(buf_read),
        .buf_write(buf_write),
        .buf_index(buf_index),
        .buf_wdata(buf_wdata),
        .buf_rdata(buf_rdata)
    );

    mcu_reg_bank reg_bank_inst (
        .clk(clk),
        .reset(reset),
        .reg_read(reg_read),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .dma_start(dma_start),
        .dma_stop(dma_stop),
        .dma_direction(dma_direction),
        .dma_length(dma_length),
        .dma_address(dma_address),
        .dma_busy(dma_busy),
        .cfg_flags(cfg_flags)
    );

    mem_buffer_dma buffer_inst (
        .clk(clk),
        .reset(reset),
        .buf_read(buf_read),
        .buf_write(buf_write),
        .buf_index(buf_index),
        .buf_wdata(buf_wdata),
        .buf_rdata(buf_rdata),
        .dma_start(dma_start),
        .dma_stop(dma_stop),
        .dma_direction(dma_direction),
        .dma_length(dma_length),
        .dma_address(dma_address),
        .dma_busy(dma_busy),
        .mem_request(mem_request),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata)
    );

endmodule

`default_nettype wire

//--- hdl/mcu_frame_parser.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_frame_parser (
    input wire logic clk,
    input wire logic reset,

    input wire logic frame_start,
    input wire logic data_ready,
    input wire mcu_bridge_pkg::byte_t rx_data,
    output mcu_bridge_pkg::byte_t tx_data,

    output logic reg_read,
    output logic reg_write,
    output mcu_bridge_pkg::reg_addr_t reg_address,
    output mcu_bridge_pkg::reg_data_t reg_wdata,
    input wire mcu_bridge_pkg::reg_data_t reg_rdata,

    output logic buf_read,
    output logic buf_write,
    output mcu_bridge_pkg::buf_index_t buf_index,
    output mcu_bridge_pkg::word_t buf_wdata,
    input wire mcu_bridge_pkg::word_t buf_rdata
);

    mcu_bridge_pkg::phase_e phase;
    mcu_bridge_pkg::cmd_e cmd;
    logic [1:0] counter;
    mcu_bridge_pkg::reg_addr_t address;
    logic word_select;

    assign reg_address = address;
    assign buf_index = {address, word_select};

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= mcu_bridge_pkg::PHASE_NOP;
            cmd <= mcu_bridge_pkg::CMD_IDENTIFY;
            counter <= 2'd0;
            address <= '0;
            word_select <= 1'b0;
            reg_read <= 1'b0;
            reg_write <= 1'b0;
            buf_read <= 1'b0;
            buf_write <= 1'b0;
        end else begin
            reg_read <= 1'b0;
            reg_write <= 1'b0;
            buf_read <= 1'b0;
            buf_write <= 1'b0;

            if (frame_start) begin
                counter <= 2'd0;
                phase <= mcu_bridge_pkg::PHASE_CMD;
            end

            // Step to the next register, or to the next word pair in the buffer.
            if (reg_read || reg_write || (word_select && (buf_read || buf_write))) begin
                address <= address + 8'd1;
            end

            if (data_ready) begin
                case (phase)
                    mcu_bridge_pkg::PHASE_CMD: begin
                        cmd <= mcu_bridge_pkg::cmd_e'(rx_data);
                        case (rx_data)
                            mcu_bridge_pkg::CMD_REG_READ,
                            mcu_bridge_pkg::CMD_REG_WRITE,
                            mcu_bridge_pkg::CMD_MEM_READ,
                            mcu_bridge_pkg::CMD_MEM_WRITE: phase <= mcu_bridge_pkg::PHASE_ADDRESS;
                            default: phase <= mcu_bridge_pkg::PHASE_NOP;
                        endcase
                    end

                    mcu_bridge_pkg::PHASE_ADDRESS: begin
                        address <= rx_data;
                        phase <= mcu_bridge_pkg::PHASE_DATA;
                        if (cmd == mcu_bridge_pkg::CMD_REG_READ) begin
                            reg_read <= 1'b1;   // Prefetch the first register.
                        end
                        if (cmd == mcu_bridge_pkg::CMD_MEM_READ) begin
                            buf_read <= 1'b1;
                            word_select <= 1'b0;
                        end
                    end

                    mcu_bridge_pkg::PHASE_DATA: begin
                        counter <= counter + 2'd1;
                        case (cmd)
                            mcu_bridge_pkg::CMD_REG_READ: begin
                                reg_read <= (counter == 2'd3);
                            end
                            mcu_bridge_pkg::CMD_REG_WRITE: begin
                                reg_wdata[counter * 8 +: 8] <= rx_data; // Little-endian.
                                reg_write <= (counter == 2'd3);
                            end
                            mcu_bridge_pkg::CMD_MEM_READ: begin
                                if (counter[0]) begin
                                    buf_read <= 1'b1;
                                    word_select <= ~word_select;
                                end
                            end
                            mcu_bridge_pkg::CMD_MEM_WRITE: begin
                                if (counter[0]) begin
                                    buf_wdata[7:0] <= rx_data;
                                    buf_write <= 1'b1;
                                    word_select <= counter[1];
                                end else begin
                                    buf_wdata[15:8] <= rx_data;
                                end
                            end
                            default: begin
                            end
                        endcase
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

    // The host samples this with each data_ready.
    always_comb begin
        tx_data = 8'h00;
        case (cmd)
            mcu_bridge_pkg::CMD_IDENTIFY: tx_data = mcu_bridge_pkg::FPGA_ID;
            mcu_bridge_pkg::CMD_REG_READ: tx_data = reg_rdata[counter * 8 +: 8];
            mcu_bridge_pkg::CMD_MEM_READ: begin
                tx_data = counter[0] ? buf_rdata[7:0] : buf_rdata[15:8];
            end
            default: tx_data = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/mcu_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_reg_bank (
    input wire logic clk,
    input wire logic reset,

    input wire logic reg_read,
    input wire logic reg_write,
    input wire mcu_bridge_pkg::reg_addr_t reg_address,
    input wire mcu_bridge_pkg::reg_data_t reg_wdata,
    output mcu_bridge_pkg::reg_data_t reg_rdata,

    output logic dma_start,
    output logic dma_stop,
    output logic dma_direction,
    output mcu_bridge_pkg::buf_index_t dma_length,
    output mcu_bridge_pkg::bus_addr_t dma_address,
    input wire logic dma_busy,

    output mcu_bridge_pkg::cfg_flags_t cfg_flags
);

    always_ff @(posedge clk) begin
        if (reg_read) begin
            case (reg_address)
                mcu_bridge_pkg::REG_MEM_ADDRESS: reg_rdata <= dma_address;
                mcu_bridge_pkg::REG_MEM_SCR: reg_rdata <= {28'd0, dma_busy, 3'b000};
                mcu_bridge_pkg::REG_CFG_SCR: reg_rdata <= {20'd0, cfg_flags};
                mcu_bridge_pkg::REG_CFG_IDENTIFIER: begin
                    reg_rdata <= mcu_bridge_pkg::CFG_IDENTIFIER;
                end
                default: reg_rdata <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dma_start <= 1'b0;
            dma_stop <= 1'b0;
            dma_direction <= 1'b0;
            cfg_flags <= mcu_bridge_pkg::CFG_RESET;
        end else begin
            dma_start <= 1'b0;
            dma_stop <= 1'b0;

            if (reg_write) begin
                case (reg_address)
                    mcu_bridge_pkg::REG_MEM_ADDRESS: begin
                        dma_address <= reg_wdata;
                    end

                    mcu_bridge_pkg::REG_MEM_SCR: begin
                        dma_start <= reg_wdata[0];
                        dma_stop <= reg_wdata[1];
                        dma_direction <= reg_wdata[2];  // Set means buffer to bus.
                        // Word count is stored as a last index.
                        dma_length <= mcu_bridge_pkg::buf_index_t'(reg_wdata[14:5] - 10'd1);
                    end

                    mcu_bridge_pkg::REG_CFG_SCR: begin
                        cfg_flags <= reg_wdata[11:0];
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/mem_buffer_dma.sv
`timescale 1ns/1ps
`default_nettype none

module mem_buffer_dma (
    input wire logic clk,
    input wire logic reset,

    input wire logic buf_read,
    input wire logic buf_write,
    input wire mcu_bridge_pkg::buf_index_t buf_index,
    input wire mcu_bridge_pkg::word_t buf_wdata,
    output mcu_bridge_pkg::word_t buf_rdata,

    input wire logic dma_start,
    input wire logic dma_stop,
    input wire logic dma_direction,
    input wire mcu_bridge_pkg::buf_index_t dma_length,
    input wire mcu_bridge_pkg::bus_addr_t dma_address,
    output logic dma_busy,

    output logic mem_request,
    output logic mem_write,
    output mcu_bridge_pkg::bus_addr_t mem_address,
    output mcu_bridge_pkg::word_t mem_wdata,
    input wire logic mem_ack,
    input wire mcu_bridge_pkg::word_t mem_rdata
);

    mcu_bridge_pkg::word_t buffer [mcu_bridge_pkg::BUF_WORDS];

    logic stop_pending;
    mcu_bridge_pkg::buf_index_t word_count;

    always_ff @(posedge clk) begin
        if (buf_read) begin
            buf_rdata <= buffer[buf_index];
        end
        if (buf_write) begin
            buffer[buf_index] <= buf_wdata;
        end

        // Bus side of the buffer.
        if (dma_busy && !mem_request) begin
            mem_wdata <= buffer[word_count];
        end
        if (dma_busy && mem_ack && !mem_write) begin
            buffer[word_count] <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dma_busy <= 1'b0;
            stop_pending <= 1'b0;
            mem_request <= 1'b0;
        end else begin
            if (dma_stop) begin
                stop_pending <= dma_busy;
            end else if (dma_start && !dma_busy) begin
                mem_write <= dma_direction;
                mem_address <= dma_address;
                word_count <= '0;
                dma_busy <= 1'b1;
            end

            if (dma_busy) begin
                if (!mem_request) begin
                    mem_request <= 1'b1;
                end

                // Request drops for one cycle after each ack.
                if (mem_ack) begin
                    mem_request <= 1'b0;
                    mem_address <= mem_address + 32'd2;
                    word_count <= word_count + 9'd1;
                    if ((word_count == dma_length) || stop_pending) begin
                        dma_busy <= 1'b0;
                        stop_pending <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- mcu_bridge.f
hdl/mcu_bridge_pkg.sv
hdl/mcu_frame_parser.sv
hdl/mcu_reg_bank.sv
hdl/mem_buffer_dma.sv
hdl/mcu_bridge_top.sv
tests/mcu_bridge_assertions.sv
tests/mcu_bridge_tb.sv

//--- tests/mcu_bridge_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_bridge_assertions (
    input wire logic clk,
    input wire logic reset,
    input wire logic dma_start,
    input wire logic dma_busy,
    input wire logic mem_request,
    input wire logic mem_ack,
    input wire mcu_bridge_pkg::bus_addr_t mem_address
);

    int failure_count = 0;

    // A request waits for its ack without moving.
    request_held: assert property (@(posedge clk) disable iff (reset)
        (mem_request && !mem_ack) |=> (mem_request && $stable(mem_address)))
    else begin
        $error("mem_request dropped or mem_address changed before mem_ack");
        failure_count++;
    end

    address_even: assert property (@(posedge clk) disable iff (reset)
        mem_request |-> (mem_address[0] == 1'b0))   // Word aligned bus.
    else begin
        $error("mem_address 0x%0h is odd", mem_address);
        failure_count++;
    end

    // Busy stays low from reset until a transfer is started.
    idle_after_reset: assert property (@(posedge clk)
        (reset || (!dma_busy && !dma_start)) |=> !dma_busy)
    else begin
        $error("dma_busy is set after reset without a dma_start");
        failure_count++;
    end

endmodule

bind mem_buffer_dma mcu_bridge_assertions bus_checks (
    .clk(clk),
    .reset(reset),
    .dma_start(dma_start),
    .dma_busy(dma_busy),
    .mem_request(mem_request),
    .mem_ack(mem_ack),
    .mem_address(mem_address)
);

`default_nettype wire

//--- tests/mcu_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_bridge_tb;

    localparam int NUM_ROWS = 14;
    localparam int MAX_ITEMS = 16;      // Longest frame payload and longest transfer, in items.
    localparam int MAX_ACK_DELAY = 4;
    localparam int MAX_POLLS = 20;
    localparam int MEM_WORDS = 1024;
    // The factor of 40 leaves room for the byte frames around each transfer.
    localparam int WATCHDOG_CYCLES = NUM_ROWS * MAX_ITEMS * (MAX_ACK_DELAY + 2) * 40;

    localparam int OP_IDENTIFY = 0;
    localparam int OP_REG_WRITE = 1;
    localparam int OP_REG_READ = 2;
    localparam int OP_BUF_WRITE = 3;
    localparam int OP_BUF_READ = 4;
    localparam int OP_TO_BUS = 5;
    localparam int OP_FROM_BUS = 6;
    localparam int OP_CFG_PORT = 7;

    logic clk;
    logic reset;
    logic frame_start;
    logic data_ready;
    mcu_bridge_pkg::byte_t rx_data;
    mcu_bridge_pkg::byte_t tx_data;
    mcu_bridge_pkg::cfg_flags_t cfg_flags;
    logic mem_request;
    logic mem_write;
    mcu_bridge_pkg::bus_addr_t mem_address;
    mcu_bridge_pkg::word_t mem_wdata;
    logic mem_ack;
    mcu_bridge_pkg::word_t mem_rdata;

    int row_op [NUM_ROWS];
    mcu_bridge_pkg::reg_addr_t row_addr [NUM_ROWS];
    int row_count [NUM_ROWS];
    logic [31:0] row_data [NUM_ROWS][MAX_ITEMS];
    logic [31:0] row_expect [NUM_ROWS][MAX_ITEMS];

    mcu_bridge_pkg::byte_t frame_tx [64];
    mcu_bridge_pkg::byte_t frame_rx [64];
    int frame_len;
    logic [31:0] write_values [MAX_ITEMS];
    logic [31:0] read_values [MAX_ITEMS];
    int error_count;
    int check_count;

    mcu_bridge_pkg::word_t mem_model [MEM_WORDS];
    logic [31:0] ack_rng;
    logic [31:0] ack_rng_next;
    logic ack_pending;
    logic [1:0] ack_delay;

    mcu_bridge_top dut (
        .clk(clk),
        .reset(reset),
        .frame_start(frame_start),
        .data_ready(data_ready),
        .rx_data(rx_data),
        .tx_data(tx_data),
        .cfg_flags(cfg_flags),
        .mem_request(mem_request),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic mcu_bridge_pkg::word_t fill_word(input int index);
        return mcu_bridge_pkg::word_t'(index * 40503) ^ 16'hC35A;
    endfunction

    assign ack_rng_next = xorshift32(ack_rng);

    // Memory model. Each request is acked 1 to 4 cycles after it is seen.
    always @(posedge clk) begin
        mem_ack <= 1'b0;
        if (reset) begin
            ack_pending <= 1'b0;
        end else if (ack_pending) begin
            if (ack_delay == 2'd0) begin
                ack_pending <= 1'b0;
                mem_ack <= 1'b1;
                if (mem_write) begin
                    mem_model[mem_address[10:1]] <= mem_wdata;
                end else begin
                    mem_rdata <= mem_model[mem_address[10:1]];
                end
            end else begin
                ack_delay <= ack_delay - 2'd1;
            end
        end else if (mem_request && !mem_ack) begin
            ack_pending <= 1'b1;
            ack_delay <= ack_rng_next[1:0];
            ack_rng <= ack_rng_next;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
            error_count++;
        end
    endtask

    // Sends frame_tx as one frame and keeps the reply byte of every strobe.
    task automatic run_frame();
        frame_start <= 1'b1;
        @(posedge clk);
        frame_start <= 1'b0;
        repeat (3) @(posedge clk);
        for (int i = 0; i < frame_len; i++) begin
            data_ready <= 1'b1;
            rx_data <= frame_tx[i];
            @(negedge clk);
            frame_rx[i] = tx_data;
            @(posedge clk);
            data_ready <= 1'b0;
            repeat (3) @(posedge clk);
        end
    endtask

    task automatic write_registers(input mcu_bridge_pkg::reg_addr_t addr, input int count);
        frame_tx[0] = mcu_bridge_pkg::CMD_REG_WRITE;
        frame_tx[1] = addr;
        for (int k = 0; k < count; k++) begin
            for (int j = 0; j < 4; j++) begin
                frame_tx[2 + 4 * k + j] = write_values[k][8 * j +: 8];   // Low byte first.
            end
        end
        frame_len = 2 + 4 * count;
        run_frame();
    endtask

    task automatic read_registers(input mcu_bridge_pkg::reg_addr_t addr, input int count);
        frame_tx[0] = mcu_bridge_pkg::CMD_REG_READ;
        frame_tx[1] = addr;
        frame_len = 2 + 4 * count;
        for (int i = 2; i < frame_len; i++) begin
            frame_tx[i] = 8'h00;
        end
        run_frame();
        for (int k = 0; k < count; k++) begin
            read_values[k] = {frame_rx[5 + 4 * k], frame_rx[4 + 4 * k],
                              frame_rx[3 + 4 * k], frame_rx[2 + 4 * k]};
        end
    endtask

    task automatic write_buffer(input mcu_bridge_pkg::reg_addr_t addr, input int count);
        frame_tx[0] = mcu_bridge_pkg::CMD_MEM_WRITE;
        frame_tx[1] = addr;
        for (int k = 0; k < count; k++) begin
            frame_tx[2 + 2 * k] = write_values[k][15:8];
            frame_tx[3 + 2 * k] = write_values[k][7:0];
        end
        frame_len = 2 + 2 * count;
        run_frame();
    endtask

    task automatic read_buffer(input mcu_bridge_pkg::reg_addr_t addr, input int count);
        frame_tx[0] = mcu_bridge_pkg::CMD_MEM_READ;
        frame_tx[1] = addr;
        frame_len = 2 + 2 * count;
        for (int i = 2; i < frame_len; i++) begin
            frame_tx[i] = 8'h00;
        end
        run_frame();
        for (int k = 0; k < count; k++) begin
            read_values[k] = {16'd0, frame_rx[2 + 2 * k], frame_rx[3 + 2 * k]};
        end
    endtask

    // Programs address and control in one streamed frame, then polls busy.
    task automatic run_transfer(input logic direction, input logic [31:0] base, input int count);
        int polls;
        write_values[0] = base;
        write_values[1] = (count << 5) | (direction << 2) | 32'd1;
        write_registers(mcu_bridge_pkg::REG_MEM_ADDRESS, 2);
        read_registers(mcu_bridge_pkg::REG_MEM_SCR, 1);
        check_value("mem_scr.busy", read_values[0][3], 32'd1);
        polls = 0;
        while (read_values[0][3] && polls < MAX_POLLS) begin
            read_registers(mcu_bridge_pkg::REG_MEM_SCR, 1);
            polls++;
        end
        if (read_values[0][3]) begin
            $display("Transfer at 0x%0h still busy after %0d polls", base, MAX_POLLS);
            error_count++;
        end
    endtask

    task automatic set_row(input int r, input int op, input mcu_bridge_pkg::reg_addr_t addr,
                           input int count);
        row_op[r] = op;
        row_addr[r] = addr;
        row_count[r] = count;
        for (int k = 0; k < MAX_ITEMS; k++) begin
            row_data[r][k] = 32'd0;
            row_expect[r][k] = 32'd0;
        end
    endtask

    task automatic build_table();
        logic [31:0] data_rng;
        logic [31:0] buf_words [MAX_ITEMS];
        data_rng = 32'd52261;
        for (int k = 0; k < MAX_ITEMS; k++) begin
            data_rng = xorshift32(data_rng);
            buf_words[k] = {16'd0, data_rng[15:0]};
        end
        set_row(0, OP_REG_READ, mcu_bridge_pkg::REG_CFG_SCR, 1);
        row_expect[0][0] = {20'd0, mcu_bridge_pkg::CFG_RESET};
        set_row(1, OP_REG_READ, mcu_bridge_pkg::REG_CFG_IDENTIFIER, 1);
        row_expect[1][0] = mcu_bridge_pkg::CFG_IDENTIFIER;
        set_row(2, OP_CFG_PORT, 8'h00, 1);
        row_expect[2][0] = {20'd0, mcu_bridge_pkg::CFG_RESET};
        set_row(3, OP_IDENTIFY, 8'h00, 3);
        for (int k = 0; k < 3; k++) begin
            row_expect[3][k] = {24'd0, mcu_bridge_pkg::FPGA_ID};
        end
        // Registers 0 to 6 in one frame. Addresses 2 to 5 are unused.
        set_row(4, OP_REG_WRITE, mcu_bridge_pkg::REG_MEM_ADDRESS, 7);
        row_data[4][0] = 32'h0000_0246;
        row_data[4][1] = 32'h0000_0000;
        row_data[4][2] = 32'h1111_2222;
        row_data[4][3] = 32'h3333_4444;
        row_data[4][4] = 32'h5555_6666;
        row_data[4][5] = 32'h7777_8888;
        row_data[4][6] = 32'hFFFF_FA5E;
        set_row(5, OP_REG_READ, mcu_bridge_pkg::REG_MEM_ADDRESS, 7);
        row_expect[5][0] = 32'h0000_0246;
        row_expect[5][6] = 32'h0000_0A5E;
        set_row(6, OP_CFG_PORT, 8'h00, 1);
        row_expect[6][0] = 32'h0000_0A5E;
        set_row(7, OP_BUF_WRITE, 8'h00, 16);
        set_row(8, OP_BUF_WRITE, 8'h40, 4);
        set_row(9, OP_BUF_READ, 8'h40, 4);
        set_row(10, OP_BUF_READ, 8'h00, 16);
        set_row(11, OP_TO_BUS, 8'h00, 16);
        row_data[11][0] = 32'h0000_0100;
        set_row(12, OP_FROM_BUS, 8'h00, 8);
        row_data[12][0] = 32'h0000_0400;
        set_row(13, OP_BUF_READ, 8'h00, 10);
        for (int k = 0; k < MAX_ITEMS; k++) begin
            row_data[7][k] = buf_words[k];
            row_expect[10][k] = buf_words[k];
            row_expect[11][k] = buf_words[k];
        end
        for (int k = 0; k < 4; k++) begin
            row_data[8][k] = buf_words[k] ^ 32'h0000_FFFF;
            row_expect[9][k] = buf_words[k] ^ 32'h0000_FFFF;
        end
        for (int k = 0; k < 10; k++) begin
            row_expect[13][k] = (k < 8) ? {16'd0, fill_word(32'h200 + k)} : buf_words[k];
        end
    endtask

    task automatic run_row(input int r);
        int base_index;
        base_index = row_data[r][0] >> 1;
        for (int k = 0; k < MAX_ITEMS; k++) begin
            write_values[k] = row_data[r][k];
        end
        case (row_op[r])
            OP_IDENTIFY: begin
                frame_tx[0] = mcu_bridge_pkg::CMD_IDENTIFY;
                for (int k = 1; k <= row_count[r]; k++) begin
                    frame_tx[k] = 8'h00;
                end
                frame_len = 1 + row_count[r];
                run_frame();
                for (int k = 0; k < row_count[r]; k++) begin
                    check_value("tx_data", frame_rx[1 + k], row_expect[r][k]);
                end
            end
            OP_REG_WRITE: write_registers(row_addr[r], row_count[r]);
            OP_REG_READ: begin
                read_registers(row_addr[r], row_count[r]);
                for (int k = 0; k < row_count[r]; k++) begin
                    check_value($sformatf("register[0x%0h]", row_addr[r] + k),
                                read_values[k], row_expect[r][k]);
                end
            end
            OP_BUF_WRITE: write_buffer(row_addr[r], row_count[r]);
            OP_BUF_READ: begin
                read_buffer(row_addr[r], row_count[r]);
                for (int k = 0; k < row_count[r]; k++) begin
                    check_value($sformatf("buffer[0x%0h]", 2 * row_addr[r] + k),
                                read_values[k], row_expect[r][k]);
                end
            end
            OP_TO_BUS: begin
                run_transfer(1'b1, row_data[r][0], row_count[r]);
                for (int k = 0; k < row_count[r]; k++) begin
                    check_value($sformatf("mem_model[0x%0h]", base_index + k),
                                {16'd0, mem_model[base_index + k]}, row_expect[r][k]);
                end
            end
            OP_FROM_BUS: run_transfer(1'b0, row_data[r][0], row_count[r]);
            OP_CFG_PORT: check_value("cfg_flags", {20'd0, cfg_flags}, row_expect[r][0]);
            default: begin
                $display("Row %0d has an unknown operation %0d", r, row_op[r]);
                error_count++;
            end
        endcase
    endtask

    initial begin
        reset = 1'b1;
        frame_start = 1'b0;
        data_ready = 1'b0;
        rx_data = 8'h00;
        mem_ack = 1'b0;
        mem_rdata = 16'h0000;
        ack_rng = 32'd52261;
        ack_pending = 1'b0;
        ack_delay = 2'd0;
        error_count = 0;
        check_count = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = fill_word(i);
        end
        build_table();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        repeat (4) @(posedge clk);
        $display("Checks: %0d, check errors: %0d, assertion errors: %0d",
                 check_count, error_count, dut.buffer_inst.bus_checks.failure_count);
        if (error_count == 0 && dut.buffer_inst.bus_checks.failure_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
